// File: src/rv32i_types.sv
package rv32i_types;

    typedef logic [31:0] rv32i_word;

    // major opcodes, only the ones this core executes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // follows funct3, sub and sra come from the alt bit
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_ops;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3;

endpackage

// File: src/ctrl_types.sv
package ctrl_types;

    // first alu operand
    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_sel_t;

    // second alu operand
    typedef enum logic {
        alumux2_rs2 = 1'b0,
        alumux2_imm = 1'b1
    } alumux2_sel_t;

    // source of the register write value
    typedef enum logic {
        regfilemux_alu  = 1'b0,
        regfilemux_load = 1'b1
    } regfilemux_sel_t;

    // load size and signedness, the funct3 of the load
    typedef rv32i_types::load_funct3 load_kind_t;

endpackage

// File: src/control_unit.sv
`timescale 1ns/100ps

module control_unit (
    input  rv32i_types::rv32i_opcode       opcode,
    input  logic [2:0]                     funct3,
    input  logic [6:0]                     funct7,
    input  rv32i_types::rv32i_word         inst,
    output rv32i_types::alu_ops            aluop,
    output logic                           alu_alt,
    output ctrl_types::alumux1_sel_t       alumux1_sel,
    output ctrl_types::alumux2_sel_t       alumux2_sel,
    output ctrl_types::regfilemux_sel_t    regfilemux_sel,
    output logic                           load_regfile,
    output logic                           mem_read,
    output logic                           mem_write,
    output rv32i_types::rv32i_word         imm
);

    rv32i_types::rv32i_word i_imm;
    rv32i_types::rv32i_word s_imm;
    rv32i_types::rv32i_word u_imm;

    assign i_imm = {{21{inst[31]}}, inst[30:20]};
    assign s_imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
    assign u_imm = {inst[31:12], 12'h000};

    always_comb begin
        // defaults give a harmless no-op
        aluop          = rv32i_types::alu_ops'(funct3);
        alu_alt        = 1'b0;
        alumux1_sel    = ctrl_types::alumux1_rs1;
        alumux2_sel    = ctrl_types::alumux2_imm;
        regfilemux_sel = ctrl_types::regfilemux_alu;
        load_regfile   = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        imm            = i_imm;

        case (opcode)
            rv32i_types::op_reg: begin
                alumux2_sel  = ctrl_types::alumux2_rs2;
                alu_alt      = funct7[5]; // sub / sra
                load_regfile = 1'b1;
            end
            rv32i_types::op_imm: begin
                // only srai uses funct7, for addi bit 30 is immediate
                alu_alt      = (funct3 == rv32i_types::alu_srl) && funct7[5];
                load_regfile = 1'b1;
            end
            rv32i_types::op_lui: begin
                aluop        = rv32i_types::alu_add; // x0 + imm
                imm          = u_imm;
                load_regfile = 1'b1;
            end
            rv32i_types::op_auipc: begin
                aluop        = rv32i_types::alu_add;
                alumux1_sel  = ctrl_types::alumux1_pc;
                imm          = u_imm;
                load_regfile = 1'b1;
            end
            rv32i_types::op_load: begin
                aluop          = rv32i_types::alu_add; // effective address
                regfilemux_sel = ctrl_types::regfilemux_load;
                load_regfile   = 1'b1;
                mem_read       = 1'b1;
            end
            rv32i_types::op_store: begin
                aluop     = rv32i_types::alu_add;
                imm       = s_imm;
                mem_write = 1'b1;
            end
            default: ; // unsupported, nothing written
        endcase
    end

endmodule

// File: src/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load,
    input  rv32i_types::rv32i_word  in,
    input  logic [4:0]              src_a,
    input  logic [4:0]              src_b,
    input  logic [4:0]              dest,
    output rv32i_types::rv32i_word  reg_a,
    output rv32i_types::rv32i_word  reg_b
);

    rv32i_types::rv32i_word data [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                data[i] <= '0;
            end
        end else if (load && dest != 5'd0) begin // x0 stays zero
            data[dest] <= in;
        end
    end

    // async reads
    assign reg_a = data[src_a];
    assign reg_b = data[src_b];

endmodule

// File: src/alu.sv
`timescale 1ns/100ps

module alu (
    input  rv32i_types::alu_ops     aluop,
    input  logic                    alt,
    input  rv32i_types::rv32i_word  a,
    input  rv32i_types::rv32i_word  b,
    output rv32i_types::rv32i_word  f
);

    always_comb begin
        case (aluop)
            rv32i_types::alu_add:  f = alt ? a - b : a + b;
            rv32i_types::alu_sll:  f = a << b[4:0];
            rv32i_types::alu_slt:  f = {31'b0, $signed(a) < $signed(b)};
            rv32i_types::alu_sltu: f = {31'b0, a < b};
            rv32i_types::alu_xor:  f = a ^ b;
            rv32i_types::alu_srl: begin
                // kept apart from the logical shift so signedness is not lost
                if (alt) begin
                    f = $signed(a) >>> b[4:0];
                end else begin
                    f = a >> b[4:0];
                end
            end
            rv32i_types::alu_or:   f = a | b;
            default:               f = a & b; // alu_and
        endcase
    end

endmodule

// File: src/load_masking.sv
`timescale 1ns/100ps

module load_masking (
    input  ctrl_types::load_kind_t  load_kind,
    input  logic [1:0]              addr_lo,
    input  rv32i_types::rv32i_word  rdata,
    output rv32i_types::rv32i_word  value
);

    rv32i_types::rv32i_word lane; // addressed byte/half moved to bit 0

    assign lane = rdata >> {addr_lo, 3'b000};

    always_comb begin
        case (load_kind)
            rv32i_types::lb:  value = {{24{lane[7]}}, lane[7:0]};
            rv32i_types::lbu: value = {24'h000000, lane[7:0]};
            rv32i_types::lh:  value = {{16{lane[15]}}, lane[15:0]};
            rv32i_types::lhu: value = {16'h0000, lane[15:0]};
            default:          value = rdata; // lw, word aligned
        endcase
    end

endmodule

// File: src/datapath.sv
`timescale 1ns/100ps

module datapath #(
    parameter rv32i_types::rv32i_word reset_pc = 32'h0000_0000
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  rv32i_types::rv32i_word  inst_rdata,
    output rv32i_types::rv32i_word  inst_addr,
    output logic                    inst_read,

    input  rv32i_types::rv32i_word  data_rdata,
    output rv32i_types::rv32i_word  data_wdata,
    output rv32i_types::rv32i_word  data_addr,
    output logic [3:0]              data_mbe,
    output logic                    data_read,
    output logic                    data_write
);

    // fetch
    rv32i_types::rv32i_word pc;

    // execute
    logic                           ex_valid;
    rv32i_types::rv32i_word         ex_pc;
    rv32i_types::rv32i_opcode       opcode;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    logic [4:0]                     rs1_addr;
    logic [4:0]                     rs2_addr;
    logic [4:0]                     rd;
    rv32i_types::alu_ops            aluop;
    logic                           alu_alt;
    ctrl_types::alumux1_sel_t       alumux1_sel;
    ctrl_types::alumux2_sel_t       alumux2_sel;
    ctrl_types::regfilemux_sel_t    regfilemux_sel;
    logic                           load_regfile;
    logic                           mem_read;
    logic                           mem_write;
    rv32i_types::rv32i_word         imm;
    rv32i_types::rv32i_word         reg_a;
    rv32i_types::rv32i_word         reg_b;
    rv32i_types::rv32i_word         rs1_val;
    rv32i_types::rv32i_word         rs2_val;
    rv32i_types::rv32i_word         alu_a;
    rv32i_types::rv32i_word         alu_b;
    rv32i_types::rv32i_word         alu_out;
    logic [1:0]                     addr_lo;

    // writeback
    logic                           wb_load;
    logic [4:0]                     wb_rd;
    rv32i_types::rv32i_word         wb_alu;
    ctrl_types::regfilemux_sel_t    wb_sel;
    ctrl_types::load_kind_t         wb_kind;
    logic [1:0]                     wb_addr_lo;
    rv32i_types::rv32i_word         load_value;
    rv32i_types::rv32i_word         wb_value;

    // fetch stage, one word per cycle once running
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= reset_pc;
            inst_read <= 1'b0;
            ex_valid  <= 1'b0;
        end else begin
            inst_read <= 1'b1;
            ex_valid  <= inst_read; // inst_rdata valid next cycle
            if (inst_read) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        ex_pc <= pc; // pc of the word now arriving on inst_rdata
    end

    assign inst_addr = pc;

    // decode straight off the memory bus
    assign opcode   = rv32i_types::rv32i_opcode'(inst_rdata[6:0]);
    assign funct3   = inst_rdata[14:12];
    assign funct7   = inst_rdata[31:25];
    assign rd       = inst_rdata[11:7];
    assign rs2_addr = inst_rdata[24:20];
    // lui adds its immediate to x0, bits 19:15 belong to the immediate
    assign rs1_addr = (opcode == rv32i_types::op_lui) ? 5'd0 : inst_rdata[19:15];

    control_unit control_unit0 (
        .opcode         (opcode),
        .funct3         (funct3),
        .funct7         (funct7),
        .inst           (inst_rdata),
        .aluop          (aluop),
        .alu_alt        (alu_alt),
        .alumux1_sel    (alumux1_sel),
        .alumux2_sel    (alumux2_sel),
        .regfilemux_sel (regfilemux_sel),
        .load_regfile   (load_regfile),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .imm            (imm)
    );

    regfile regfile0 (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (wb_load),
        .in    (wb_value),
        .src_a (rs1_addr),
        .src_b (rs2_addr),
        .dest  (wb_rd),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    // wb -> ex bypass, wb_load is never set for x0
    assign rs1_val = (wb_load && wb_rd == rs1_addr) ? wb_value : reg_a;
    assign rs2_val = (wb_load && wb_rd == rs2_addr) ? wb_value : reg_b;

    assign alu_a = (alumux1_sel == ctrl_types::alumux1_pc) ? ex_pc : rs1_val;
    assign alu_b = (alumux2_sel == ctrl_types::alumux2_imm) ? imm : rs2_val;

    alu alu0 (
        .aluop (aluop),
        .alt   (alu_alt),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_out)
    );

    // data port, driven in execute
    assign addr_lo    = alu_out[1:0];
    assign data_addr  = {alu_out[31:2], 2'b00};
    assign data_read  = ex_valid && mem_read;
    assign data_write = ex_valid && mem_write;
    assign data_wdata = rs2_val << {addr_lo, 3'b000}; // move into byte lane

    always_comb begin
        data_mbe = 4'b0000;
        if (data_write) begin
            case (rv32i_types::store_funct3'(funct3))
                rv32i_types::sb: data_mbe = 4'b0001 << addr_lo;
                rv32i_types::sh: data_mbe = 4'b0011 << addr_lo;
                default:         data_mbe = 4'b1111;
            endcase
        end
    end

    // writeback register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_load <= 1'b0;
        end else begin
            wb_load <= ex_valid && load_regfile && rd != 5'd0;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd      <= rd;
        wb_alu     <= alu_out;
        wb_sel     <= regfilemux_sel;
        wb_kind    <= ctrl_types::load_kind_t'(funct3);
        wb_addr_lo <= addr_lo;
    end

    load_masking load_masking0 (
        .load_kind (wb_kind),
        .addr_lo   (wb_addr_lo),
        .rdata     (data_rdata),
        .value     (load_value)
    );

    assign wb_value = (wb_sel == ctrl_types::regfilemux_load) ? load_value : wb_alu;

endmodule

// File: verification/datapath_checker.sv
`timescale 1ns/100ps

module datapath_checker #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input logic        clk,
    input logic        rst_n,
    input logic        inst_read,
    input logic [31:0] inst_addr,
    input logic        data_read,
    input logic        data_write,
    input logic [3:0]  data_mbe,
    input logic [31:0] data_addr,
    input logic [31:0] data_wdata
);

    logic [31:0] prog [128];
    logic [31:0] mem [128];       // data image with word 0 at the x1 base
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_pc [$];
    logic [3:0]  exp_mbe [$];
    int          stores_left = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests = 0;
    logic        was_reset = 1'b0; // dut saw reset at the last edge
    logic        prev_read = 1'b0;
    logic [31:0] prev_addr = 32'h0;

    function automatic logic [31:0] byte_mask(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] load_model(input logic [2:0] f3, input logic [1:0] lo,
                                               input logic [31:0] w);
        logic [31:0] s;
        s = w >> {lo, 3'b000};
        case (f3)
            3'd0: return {{24{s[7]}}, s[7:0]};
            3'd1: return {{16{s[15]}}, s[15:0]};
            3'd4: return {24'h0, s[7:0]};
            3'd5: return {16'h0, s[15:0]};
            default: return w;
        endcase
    endfunction

    // words outside the program are fetched as nops
    function automatic logic fetched_load(input logic [31:0] a);
        logic [31:0] idx;
        idx = (a - reset_pc) >> 2;
        return (idx < 32'd128) && (prog[idx[6:0]][6:0] == rv32i_types::op_load);
    endfunction

    task load_inst(input int i, input logic [31:0] w);
        prog[i] = w;
    endtask

    task load_data(input int i, input logic [31:0] w);
        mem[i] = w;
    endtask

    // in-order run of the whole program to collect the expected stores
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] w;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] mask;
        logic [3:0]  mbe;
        logic        wr;
        for (int r = 0; r < 32; r++) begin
            regs[r] = 32'h0;
        end
        exp_addr.delete();
        exp_data.delete();
        exp_pc.delete();
        exp_mbe.delete();
        for (int i = 0; i < 128; i++) begin
            w   = prog[i];
            pc  = reset_pc + 4 * i;
            a   = regs[w[19:15]];
            b   = regs[w[24:20]];
            res = 32'h0;
            wr  = 1'b1;
            case (w[6:0])
                rv32i_types::op_lui:   res = {w[31:12], 12'h000};
                rv32i_types::op_auipc: res = pc + {w[31:12], 12'h000};
                rv32i_types::op_imm:
                    res = alu_model(w[14:12], w[14:12] == 3'd5 && w[30], a,
                                    {{20{w[31]}}, w[31:20]});
                rv32i_types::op_reg:   res = alu_model(w[14:12], w[30], a, b);
                rv32i_types::op_load: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    res  = load_model(w[14:12], addr[1:0], mem[addr[8:2]]);
                end
                rv32i_types::op_store: begin
                    wr   = 1'b0;
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    case (w[13:12])
                        2'd0:    mbe = 4'b0001 << addr[1:0];
                        2'd1:    mbe = 4'b0011 << addr[1:0];
                        default: mbe = 4'b1111;
                    endcase
                    b    = b << {addr[1:0], 3'b000}; // into its byte lane
                    mask = byte_mask(mbe);
                    mem[addr[8:2]] = (mem[addr[8:2]] & ~mask) | (b & mask);
                    exp_addr.push_back({addr[31:2], 2'b00});
                    exp_data.push_back(b);
                    exp_pc.push_back(pc);
                    exp_mbe.push_back(mbe);
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                regs[w[11:7]] = res;
            end
        end
        stores_left = exp_addr.size();
    endtask

    task note_error();
        errors++;
        test_errors++;
    endtask

    task check_word(input string name, input logic [31:0] expv, input logic [31:0] act);
        if (expv !== act) begin
            $display("ERR %s expected %h got %h at %0t", name, expv, act, $time);
            note_error();
        end
    endtask

    task end_test(input string name);
        if (exp_addr.size() != 0) begin
            $display("%0d expected stores never appeared on the data port", exp_addr.size());
            note_error();
        end
        tests++;
        $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "bad", test_errors);
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        if (was_reset && (inst_read || data_read || data_write || data_mbe != 4'h0)) begin
            $display("strobe active during or right after reset at %0t", $time);
            note_error();
        end
        if (rst_n && inst_read) begin
            check_word("inst_addr", prev_read ? prev_addr + 32'd4 : reset_pc, inst_addr);
        end
        if (rst_n) begin
            // a load fetched last cycle reads memory now
            check_word("data_read", {31'h0, prev_read && fetched_load(prev_addr)},
                       {31'h0, data_read});
        end
        if (rst_n && data_write) begin
            if (exp_addr.size() == 0) begin
                $display("unexpected store to %h at %0t", data_addr, $time);
                note_error();
            end else begin
                check_word("data_addr", exp_addr[0], data_addr);
                check_word("data_mbe", {28'h0, exp_mbe[0]}, {28'h0, data_mbe});
                check_word("data_wdata", exp_data[0] & byte_mask(exp_mbe[0]),
                           data_wdata & byte_mask(exp_mbe[0]));
                // store shows up one cycle after its fetch
                check_word("inst_addr one cycle before store", exp_pc[0], prev_addr);
                exp_addr.delete(0);
                exp_data.delete(0);
                exp_pc.delete(0);
                exp_mbe.delete(0);
                stores_left--;
            end
        end
        was_reset <= !rst_n;
        prev_read <= inst_read && rst_n;
        prev_addr <= inst_addr;
    end

endmodule

// File: verification/datapath_tb.sv
`timescale 1ns/100ps

module datapath_tb;

    localparam logic [31:0] reset_pc = 32'h0000_0100;
    localparam int prog_words = 128;
    localparam int body_len = 60;
    localparam int prog_len = 1 + body_len + 30;
    localparam int num_tests = 4;
    localparam logic [31:0] nop = 32'h0000_0013; // addi x0, x0, 0

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] inst_rdata = nop;
    logic [31:0] data_rdata = 32'h0;
    logic [31:0] inst_addr;
    logic        inst_read;
    logic [31:0] data_wdata;
    logic [31:0] data_addr;
    logic [3:0]  data_mbe;
    logic        data_read;
    logic        data_write;

    logic [31:0] imem [prog_words];
    logic [31:0] dmem [prog_words]; // base 0x10000 with the dump area from offset 0x100
    logic [31:0] rng = 32'h154a;

    always #50 clk = ~clk;

    datapath #(.reset_pc(reset_pc)) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_rdata (inst_rdata),
        .inst_addr  (inst_addr),
        .inst_read  (inst_read),
        .data_rdata (data_rdata),
        .data_wdata (data_wdata),
        .data_addr  (data_addr),
        .data_mbe   (data_mbe),
        .data_read  (data_read),
        .data_write (data_write)
    );

    datapath_checker #(.reset_pc(reset_pc)) checker0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .data_read  (data_read),
        .data_write (data_write),
        .data_mbe   (data_mbe),
        .data_addr  (data_addr),
        .data_wdata (data_wdata)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] rnd();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] a);
        logic [31:0] idx;
        idx = (a - reset_pc) >> 2;
        return (idx < prog_words) ? imem[idx[6:0]] : nop;
    endfunction

    // one-cycle memories
    always @(posedge clk) begin
        if (inst_read) begin
            inst_rdata <= fetch_word(inst_addr);
        end
        if (data_read) begin
            data_rdata <= dmem[data_addr[8:2]];
        end
        if (data_write) begin
            dmem[data_addr[8:2]] <= (dmem[data_addr[8:2]] & ~lane_mask(data_mbe))
                                  | (data_wdata & lane_mask(data_mbe));
        end
    end

    // mix 0 alu only, 1 load heavy, 2 store heavy, 3 dependent chain
    function logic [31:0] pick_inst(input int mix, input logic [4:0] rd,
                                    input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [7:0]  off;
        logic [6:0]  f7;
        logic [3:0]  n_load;
        logic [3:0]  n_store;
        r       = rnd();
        n_load  = (mix == 1) ? 4'd8 : (mix == 2) ? 4'd4 : (mix == 3) ? 4'd5 : 4'd0;
        n_store = (mix == 2) ? 4'd6 : (mix == 3) ? 4'd2 : 4'd0;
        off     = r[15:8];
        if (r[19:16] < n_load) begin
            f3  = (r[2:0] == 3'd3 || r[2:1] == 2'b11) ? 3'b010 : r[2:0];
            off = off & ~((8'd1 << f3[1:0]) - 8'd1); // size aligned
            return {4'h0, off, 5'd1, f3, rd, rv32i_types::op_load};
        end
        if (r[19:16] < n_load + n_store) begin
            f3  = (r[1:0] == 2'd3) ? 3'b010 : {1'b0, r[1:0]};
            off = off & ~((8'd1 << f3[1:0]) - 8'd1);
            return {4'h0, off[7:5], rs2, 5'd1, f3, off[4:0], rv32i_types::op_store};
        end
        f3 = r[2:0];
        case (r[22:21])
            2'b00, 2'b10: begin
                f7 = (r[24] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
                return {f7, rs2, rs1, f3, rd, rv32i_types::op_reg};
            end
            2'b01: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    f7 = (f3 == 3'd5 && r[24]) ? 7'h20 : 7'h00; // srai
                    return {f7, r[29:25], rs1, f3, rd, rv32i_types::op_imm};
                end
                return {r[31:20], rs1, f3, rd, rv32i_types::op_imm};
            end
            default: return {r[31:12], rd, r[23] ? rv32i_types::op_lui : rv32i_types::op_auipc};
        endcase
    endfunction

    task automatic run_test(input int mix, input string name);
        logic [31:0] w;
        logic [11:0] off;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        // x1 = 0x10000 as the data base
        imem[0] = {20'h00010, 5'd1, rv32i_types::op_lui};
        prev = 5'd1;
        for (int i = 1; i <= body_len; i++) begin
            w    = rnd();
            rd   = 5'd2 + 5'(w % 30);
            rs1  = (mix == 3) ? prev : w[12:8];
            rs2  = (mix == 3 && w[13]) ? prev : w[20:16];
            imem[i] = pick_inst(mix, rd, rs1, rs2);
            prev = rd;
        end
        for (int r = 2; r < 32; r++) begin
            off = 12'h100 + 12'(4 * (r - 2));
            imem[body_len + r - 1] = {off[11:5], 5'(r), 5'd1, 3'b010, off[4:0],
                                      rv32i_types::op_store};
        end
        for (int i = prog_len; i < prog_words; i++) begin
            imem[i] = nop;
        end
        for (int i = 0; i < prog_words; i++) begin
            w       = rnd();
            dmem[i] = (i < 64) ? w : 32'h0;
            checker0.load_inst(i, imem[i]);
            checker0.load_data(i, dmem[i]);
        end
        checker0.run_model();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // program runs once through, later stores count as missing
        for (int c = 0; c < prog_len + 20 && checker0.stores_left != 0; c++) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // room for a stray extra store
        @(negedge clk);
        checker0.end_test(name);
    endtask

    initial begin
        #(num_tests * (prog_len + 40) * 100);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

    initial begin
        run_test(0, "reset_alu");
        run_test(1, "loads");
        run_test(2, "stores");
        run_test(3, "forwarding");
        $display("%0d tests run, %0d errors", checker0.tests, checker0.errors);
        if (checker0.errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim.f
src/rv32i_types.sv
src/ctrl_types.sv
src/control_unit.sv
src/regfile.sv
src/alu.sv
src/load_masking.sv
src/datapath.sv
verification/datapath_checker.sv
verification/datapath_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f sim.f --top-module datapath_tb -Mdir build -o datapath_sim
	./build/datapath_sim | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf build sim.log
